// ==== hdl/leaf_consts.svh ====
`ifndef LEAF_CONSTS_SVH
`define LEAF_CONSTS_SVH

// Packet fields run from the valid bit at the top down to the payload.
`define PACKET_BITS   49
`define LEAF_BITS     5
`define PORT_BITS     4
`define SEQ_BITS      7

// The payload takes whatever the header fields leave over.
`define PAYLOAD_BITS  (`PACKET_BITS - 1 - `LEAF_BITS - `PORT_BITS - `SEQ_BITS)

// A route is a destination leaf and port, packed the same way as in a packet.
`define ROUTE_BITS    (`LEAF_BITS + `PORT_BITS)

`define NUM_IN_PORTS  7
`define NUM_OUT_PORTS 5
`define OUT_IDX_BITS  3

// Entries per input port buffer, a power of two.
`define BUF_DEPTH     4

`endif

// ==== hdl/leaf_pkg.sv ====
`default_nettype none

`include "leaf_consts.svh"

package leaf_pkg;

    typedef struct packed {
        logic                     valid;
        logic [`LEAF_BITS-1:0]    dest_leaf;
        logic [`PORT_BITS-1:0]    dest_port;
        logic [`SEQ_BITS-1:0]     seq;
        logic [`PAYLOAD_BITS-1:0] payload;
    } bft_packet_t;

    // Port zero is reserved for configuration traffic.
    typedef enum logic {
        PKT_DATA   = 1'b0,
        PKT_CONFIG = 1'b1
    } pkt_kind_e;

    typedef struct packed {
        logic [`LEAF_BITS-1:0] dest_leaf;
        logic [`PORT_BITS-1:0] dest_port;
    } route_t;

    typedef struct packed {
        logic                     en;
        logic [`OUT_IDX_BITS-1:0] index; // Output port whose route is written.
        route_t                   route;
    } cfg_wr_t;

    typedef struct packed {
        logic                     vld;
        logic [`PAYLOAD_BITS-1:0] data;
    } user_word_t;

endpackage

`default_nettype wire

// ==== hdl/leaf_rx_router.sv ====
`default_nettype none

`include "leaf_consts.svh"

module leaf_rx_router import leaf_pkg::*; #(
    parameter logic [`LEAF_BITS-1:0] LEAF_ID = '0
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  bft_packet_t                    din,
    output user_word_t [`NUM_IN_PORTS-1:0] wr,
    output cfg_wr_t                        cfg
);

    logic                     hit_q;
    bft_packet_t              pkt_q;
    pkt_kind_e                kind;
    logic [`NUM_IN_PORTS-1:0] wr_vld;

    // Packets for other leaves are dropped here.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= din.valid && (din.dest_leaf == LEAF_ID);
        end
    end

    always_ff @(posedge clk) begin
        pkt_q <= din;
    end

    assign kind = (pkt_q.dest_port == '0) ? PKT_CONFIG : PKT_DATA;

    // Port number n in the packet feeds buffer n-1.
    always_comb begin
        for (int i = 0; i < `NUM_IN_PORTS; i++) begin
            wr_vld[i]  = hit_q && (kind == PKT_DATA) && (pkt_q.dest_port == 4'(i + 1));
            wr[i].vld  = wr_vld[i];
            wr[i].data = pkt_q.payload;
        end
    end

    always_comb begin
        cfg.en    = hit_q && (kind == PKT_CONFIG);
        cfg.index = pkt_q.seq[`OUT_IDX_BITS-1:0];    // Table index rides in seq.
        cfg.route = pkt_q.payload[`ROUTE_BITS-1:0];
    end

    // A registered packet lands in one place at most.
    a_single_target: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({wr_vld, cfg.en})
    );

endmodule

`default_nettype wire

// ==== hdl/leaf_port_buffer.sv ====
`default_nettype none

`include "leaf_consts.svh"

module leaf_port_buffer import leaf_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  user_word_t wr,
    output user_word_t to_user,
    input  logic       ack,
    output logic       overflow
);

    localparam int PTR_BITS = $clog2(`BUF_DEPTH);
    localparam logic [PTR_BITS:0] DEPTH = `BUF_DEPTH;

    logic [`PAYLOAD_BITS-1:0] mem [`BUF_DEPTH];
    logic [PTR_BITS-1:0]      wr_ptr;
    logic [PTR_BITS-1:0]      rd_ptr;
    logic [PTR_BITS:0]        count;
    logic                     full;
    logic                     push;
    logic                     pop;

    assign full = (count == DEPTH);
    assign push = wr.vld && !full;
    assign pop  = to_user.vld && ack;

    // The head entry is presented without waiting for a read request.
    assign to_user.vld  = (count != '0);
    assign to_user.data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the depth.
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr.vld && full) begin
                overflow <= 1'b1; // Stays set until reset.
            end
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= DEPTH
    );

    // The user side may rely on the head word until it acknowledges it.
    a_head_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        to_user.vld && !ack |=> to_user.vld && $stable(to_user.data)
    );

endmodule

`default_nettype wire

// ==== hdl/leaf_tx_arbiter.sv ====
`default_nettype none

`include "leaf_consts.svh"

module leaf_tx_arbiter import leaf_pkg::*; (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            resend,
    input  cfg_wr_t                         cfg,
    input  user_word_t [`NUM_OUT_PORTS-1:0] from_user,
    output logic [`NUM_OUT_PORTS-1:0]       ack_to_user,
    output bft_packet_t                     dout
);

    route_t                    route_tbl [`NUM_OUT_PORTS];
    logic [`SEQ_BITS-1:0]      seq_cnt   [`NUM_OUT_PORTS];
    logic [`OUT_IDX_BITS-1:0]  last_q;
    logic [`OUT_IDX_BITS-1:0]  grant_idx;
    logic [`NUM_OUT_PORTS-1:0] grant;
    logic                      take;
    logic                      out_vld_q;
    bft_packet_t               out_q;

    // Search starts one past the port granted last.
    always_comb begin
        int   idx;
        logic found;
        grant     = '0;
        grant_idx = last_q;
        found     = 1'b0;
        for (int k = 1; k <= `NUM_OUT_PORTS; k++) begin
            idx = (int'(last_q) + k) % `NUM_OUT_PORTS;
            if (!found && from_user[idx].vld) begin
                grant[idx] = 1'b1;
                grant_idx  = 3'(idx);
                found      = 1'b1;
            end
        end
    end

    assign ack_to_user = resend ? '0 : grant;
    assign take        = |ack_to_user;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int j = 0; j < `NUM_OUT_PORTS; j++) begin
                route_tbl[j] <= '0;
                seq_cnt[j]   <= '0;
            end
            last_q    <= 3'(`NUM_OUT_PORTS - 1); // Port 0 wins the first round.
            out_vld_q <= 1'b0;
        end else begin
            if (cfg.en && (cfg.index < 3'(`NUM_OUT_PORTS))) begin
                route_tbl[cfg.index] <= cfg.route;
            end
            if (take) begin
                seq_cnt[grant_idx] <= seq_cnt[grant_idx] + 1'b1;
                last_q             <= grant_idx;
            end
            if (!resend) out_vld_q <= take; // Resend freezes the pending packet.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_q.valid     <= 1'b1;
            out_q.dest_leaf <= route_tbl[grant_idx].dest_leaf;
            out_q.dest_port <= route_tbl[grant_idx].dest_port;
            out_q.seq       <= seq_cnt[grant_idx];
            out_q.payload   <= from_user[grant_idx].data;
        end
    end

    // An empty word goes out when idle or while the switch asks for a resend.
    always_comb begin
        dout       = out_q;
        dout.valid = out_vld_q;
        if (resend || !out_vld_q) dout = '0;
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(grant)
    );

endmodule

`default_nettype wire

// ==== hdl/leaf_interface.sv ====
`default_nettype none

`include "leaf_consts.svh"

module leaf_interface import leaf_pkg::*; #(
    parameter logic [`LEAF_BITS-1:0] LEAF_ID = '0
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            resend,
    input  bft_packet_t                     din,
    output bft_packet_t                     dout,
    output user_word_t [`NUM_IN_PORTS-1:0]  to_user,
    input  logic [`NUM_IN_PORTS-1:0]        ack_from_user,
    input  user_word_t [`NUM_OUT_PORTS-1:0] from_user,
    output logic [`NUM_OUT_PORTS-1:0]       ack_to_user,
    output logic [`NUM_IN_PORTS-1:0]        overflow
);

    user_word_t [`NUM_IN_PORTS-1:0] wr;
    cfg_wr_t                        cfg;

    // Network to user direction.
    leaf_rx_router #(
        .LEAF_ID(LEAF_ID)
    ) u_rx_router (
        .clk    (clk),
        .arst_n (arst_n),
        .din    (din),
        .wr     (wr),
        .cfg    (cfg)
    );

    // One buffer per user input port, bit i serves port number i+1.
    genvar i;
    generate
        for (i = 0; i < `NUM_IN_PORTS; i++) begin : g_port_buf
            leaf_port_buffer u_port_buffer (
                .clk      (clk),
                .arst_n   (arst_n),
                .wr       (wr[i]),
                .to_user  (to_user[i]),
                .ack      (ack_from_user[i]),
                .overflow (overflow[i])
            );
        end
    endgenerate

    // User to network direction, routed by the table that config packets fill.
    leaf_tx_arbiter u_tx_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .resend      (resend),
        .cfg         (cfg),
        .from_user   (from_user),
        .ack_to_user (ack_to_user),
        .dout        (dout)
    );

endmodule

`default_nettype wire

// ==== verif/tb_leaf_interface.sv ====
`default_nettype none

`include "leaf_consts.svh"

module tb_leaf_interface import leaf_pkg::*; ();

    typedef logic [`PAYLOAD_BITS-1:0] word_t;

    localparam int TIMEOUT = 200;

    logic                            clk;
    logic                            arst_n;
    logic                            resend;
    bft_packet_t                     din;
    bft_packet_t                     dout;
    user_word_t [`NUM_IN_PORTS-1:0]  to_user;
    logic [`NUM_IN_PORTS-1:0]        ack_from_user;
    user_word_t [`NUM_OUT_PORTS-1:0] from_user;
    logic [`NUM_OUT_PORTS-1:0]       ack_to_user;
    logic [`NUM_IN_PORTS-1:0]        overflow;

    word_t                     rx_q [`NUM_IN_PORTS][$]; // Words the user side accepted.
    bft_packet_t               out_q [$];
    word_t                     tx_q [`NUM_OUT_PORTS][$];
    word_t                     tx_cur [`NUM_OUT_PORTS];
    logic [`NUM_OUT_PORTS-1:0] tx_busy;
    int                        model_seq [word_t]; // Seq that each sent word should carry.
    int                        sent_cnt [`NUM_OUT_PORTS];
    int                        errors;
    int                        tests;
    int                        failed;
    int                        test_base;

    leaf_interface #(.LEAF_ID(5'd3)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Transfers are sampled mid-cycle, where every handshake signal is settled.
    always @(negedge clk) begin
        if (arst_n) begin
            for (int i = 0; i < `NUM_IN_PORTS; i++) begin
                if (to_user[i].vld && ack_from_user[i]) rx_q[i].push_back(to_user[i].data);
            end
            for (int j = 0; j < `NUM_OUT_PORTS; j++) begin
                if (from_user[j].vld && ack_to_user[j]) begin
                    model_seq[from_user[j].data] = sent_cnt[j] % (1 << `SEQ_BITS);
                    sent_cnt[j]++;
                end
            end
            if (dout.valid) out_q.push_back(dout);
            assert (!resend || (dout == '0 && ack_to_user == '0)) else begin
                $display("Resend ignored: dout %h, ack_to_user %h", dout, ack_to_user);
                errors++;
            end
        end
    end

    // The user output ports hold each word until the arbiter acknowledges it.
    initial begin
        tx_busy   = '0;
        from_user = '0;
        forever begin
            @(negedge clk);
            for (int j = 0; j < `NUM_OUT_PORTS; j++) begin
                if (from_user[j].vld && ack_to_user[j]) tx_busy[j] = 1'b0;
                if (!tx_busy[j] && tx_q[j].size() > 0) begin
                    tx_cur[j]  = tx_q[j].pop_front();
                    tx_busy[j] = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            for (int j = 0; j < `NUM_OUT_PORTS; j++) begin
                from_user[j].vld  = tx_busy[j];
                from_user[j].data = tx_busy[j] ? tx_cur[j] : '0;
            end
        end
    end

    task automatic inject(input word_t leaf, input word_t port, input word_t seq,
                          input word_t data);
        din.valid     = 1'b1;
        din.dest_leaf = leaf[`LEAF_BITS-1:0];
        din.dest_port = port[`PORT_BITS-1:0];
        din.seq       = seq[`SEQ_BITS-1:0];
        din.payload   = data;
        step();
        din = '0;
    endtask

    task automatic expect_user_word(input int idx, input word_t exp);
        int    n;
        word_t got;
        n = 0;
        while (rx_q[idx].size() == 0 && n < TIMEOUT) begin
            step();
            n++;
        end
        assert (rx_q[idx].size() > 0) else begin
            $display("Timeout: no word reached user input port %0d", idx);
            errors++;
        end
        if (rx_q[idx].size() > 0) begin
            got = rx_q[idx].pop_front();
            assert (got == exp) else begin
                $display("Mismatch to_user[%0d].data: got %h, expected %h", idx, got, exp);
                errors++;
            end
        end
    endtask

    task automatic expect_packet(input word_t leaf, input word_t port, input word_t seq,
                                 input word_t data);
        int          n;
        int          exp_seq;
        bft_packet_t got;
        bft_packet_t exp;
        n = 0;
        while (out_q.size() == 0 && n < TIMEOUT) begin
            step();
            n++;
        end
        assert (out_q.size() > 0) else begin
            $display("Timeout: no packet appeared on dout");
            errors++;
        end
        if (out_q.size() > 0) begin
            got = out_q.pop_front();
            exp = {1'b1, leaf[`LEAF_BITS-1:0], port[`PORT_BITS-1:0], seq[`SEQ_BITS-1:0], data};
            exp_seq = model_seq.exists(got.payload) ? model_seq[got.payload] : -1;
            assert (got == exp) else begin
                $display("Mismatch dout: got %h, expected %h", got, exp);
                errors++;
            end
            assert (int'(got.seq) == exp_seq) else begin
                $display("Mismatch dout.seq: got %h, counted sends give %h", got.seq, exp_seq);
                errors++;
            end
        end
    endtask

    // Anything still queued after the settle time was never expected.
    task automatic close_test();
        repeat (8) step();
        for (int i = 0; i < `NUM_IN_PORTS; i++) begin
            assert (rx_q[i].size() == 0) else begin
                $display("Unexpected word delivered on user input port %0d", i);
                errors++;
            end
            rx_q[i].delete();
        end
        assert (out_q.size() == 0) else begin
            $display("Unexpected packet sent on dout");
            errors++;
        end
        out_q.delete();
        tests++;
        if (errors != test_base) failed++;
        $display("Test %0d: %s, %0d errors", tests, (errors == test_base) ? "pass" : "fail",
                 errors - test_base);
        test_base = errors;
    endtask

    initial begin
        logic [8*12-1:0]  cmd;
        logic [8*200-1:0] line;
        word_t            a;
        word_t            b;
        word_t            c;
        word_t            d;
        int               fd;
        int               code;
        arst_n        = 1'b0;
        resend        = 1'b0;
        din           = '0;
        ack_from_user = '1; // Users accept words unless a test says otherwise.
        fd = $fopen("verif/leaf_stimulus.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open the stimulus file");
            errors++;
        end
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
        while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#":        code = $fgets(line, fd);
                "pkt": begin
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    inject(a, b, c, d);
                end
                "send": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    tx_q[int'(a)].push_back(b);
                end
                "ack": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    ack_from_user[int'(a)] = b[0];
                end
                "resend": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    resend = a[0];
                    repeat (b) step();
                end
                "exp_user": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    expect_user_word(int'(a), b);
                end
                "exp_out": begin
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    expect_packet(a, b, c, d);
                end
                "exp_ovf": begin
                    code = $fscanf(fd, "%h", a);
                    assert (overflow == a[`NUM_IN_PORTS-1:0]) else begin
                        $display("Mismatch overflow: got %h, expected %h", overflow, a);
                        errors++;
                    end
                end
                "end":      close_test();
                default: begin
                    $display("Unknown command in the stimulus file");
                    errors++;
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/leaf_stimulus.txt ====
# pkt leaf port seq payload, send out_port data, ack in_port on, resend level cycles
# exp_user in_port data, exp_out leaf port seq data, exp_ovf vector, end. All hex, in_port 0 is packet port 1.
pkt 3 2 0 a1b2c3d4
pkt 5 2 0 deadbeef
exp_user 1 a1b2c3d4
exp_ovf 00
end
pkt 3 0 2 94
send 2 20000000
send 2 20000001
send 2 20000002
exp_out 9 4 0 20000000
exp_out 9 4 1 20000001
exp_out 9 4 2 20000002
end
ack 0 0
pkt 3 1 0 c0000000
pkt 3 1 0 c0000001
pkt 3 1 0 c0000002
pkt 3 1 0 c0000003
pkt 3 1 0 c0000004
ack 0 1
exp_user 0 c0000000
exp_user 0 c0000001
exp_user 0 c0000002
exp_user 0 c0000003
exp_ovf 01
end
resend 1 2
send 2 24000000
resend 1 a
resend 0 0
exp_out 9 4 3 24000000
end
pkt 3 0 0 11
pkt 3 0 3 26
send 0 50000000
send 0 50000001
send 3 53000000
send 3 53000001
exp_out 2 6 0 53000000
exp_out 1 1 0 50000000
exp_out 2 6 1 53000001
exp_out 1 1 1 50000001
end

// ==== list.f ====
+incdir+hdl
hdl/leaf_pkg.sv
hdl/leaf_rx_router.sv
hdl/leaf_port_buffer.sv
hdl/leaf_tx_arbiter.sv
hdl/leaf_interface.sv
verif/tb_leaf_interface.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_leaf_interface
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only when the log holds the pass line.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
